// ==== Makefile ====
# verilator flow for the pipeline controller testbench

TOP := pipe_ctrl_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f pipe_ctrl.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/pipe_ctrl_assertions.sv ====
`timescale 1ns/1ps

module pipe_ctrl_assertions
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pc_set_o,
  input  ctrl_pc_pkg::pc_mux_t pc_mux_o,
  input  logic                 exc_ack_o,
  input  logic                 halt_if_o,
  input  logic                 halt_id_o,
  input  logic                 jr_stall_o
);

  import ctrl_pc_pkg::*;

  ////////////////////////////////////////////////////////////
  // controller output rules
  ////////////////////////////////////////////////////////////

  // an acknowledged exception always redirects to the handler
  exc_ack_redirects: assert property (@(posedge clk) disable iff (!rst_n)
    exc_ack_o |-> (pc_set_o && (pc_mux_o == PC_EXCEPTION)))
    else $error("exception acknowledge without a redirect to the handler");

  // a jalr waiting for operand a never jumps to its target yet
  jr_stall_holds_jump: assert property (@(posedge clk) disable iff (!rst_n)
    jr_stall_o |-> !(pc_set_o && (pc_mux_o == PC_JUMP)))
    else $error("jump redirect issued while the jalr operand is still pending");

  // ID only halts on a flush (IF halted too) or on an exception
  halt_id_cause: assert property (@(posedge clk) disable iff (!rst_n)
    halt_id_o |-> (halt_if_o || exc_ack_o))
    else $error("ID halted without an IF halt or exception acknowledge");

endmodule

// attach to every controller instance
bind pipe_ctrl pipe_ctrl_assertions i_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .pc_set_o      (pc_set_o),
  .pc_mux_o      (pc_mux_o),
  .exc_ack_o     (exc_ack_o),
  .halt_if_o     (halt_if_o),
  .halt_id_o     (halt_id_o),
  .jr_stall_o    (jr_stall_o)
);

// ==== bench/pipe_ctrl_tb.sv ====
`timescale 1ns/1ps

module pipe_ctrl_tb;

  import ctrl_pc_pkg::*;
  import ctrl_operand_pkg::*;

  localparam int TABLE_LEN   = 24;
  // table rows plus the fsm sequences
  localparam int CYCLE_LIMIT = TABLE_LEN * 4 + 200;

  // one combinational check in DECODE
  typedef struct packed {
    logic          misaligned;
    logic          mult;
    logic          data_req;
    logic          illegal;
    jump_kind_t    jump;
    operand_mask_t ex_m;
    operand_mask_t wb_m;
    operand_mask_t alu_m;
    logic          we_ex;
    logic          we_wb;
    logic          alu_we;
    fw_sel_t       exp_a;
    fw_sel_t       exp_b;
    fw_sel_t       exp_c;
    logic          exp_load;
    logic          exp_jr;
    logic          exp_dwe;
  } row_t;

  logic clk;
  logic rst_n;
  logic fetch_enable, instr_valid, id_ready, ex_valid, wb_valid;
  logic illegal_insn, eret_insn, pipe_flush, branch_taken_ex, exc_req;
  logic data_req_ex, data_misaligned, mult_multicycle;
  logic we_ex, we_wb, alu_we;
  jump_kind_t jump_in_dec, jump_in_id;
  operand_mask_t ex_match, wb_match, alu_match;

  logic core_busy, is_decoding, instr_req, pc_set, exc_ack, exc_save_id;
  logic exc_restore_id, halt_if, halt_id, deassert_we, load_stall, jr_stall;
  pc_mux_t pc_mux;
  fw_sel_t fw_a, fw_b, fw_c;

  row_t table_q [TABLE_LEN];
  int   errors   = 0;
  int   timeouts = 0;
  int   cycles   = 0;

  pipe_ctrl i_dut (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .instr_valid_i (instr_valid),
    .id_ready_i (id_ready), .ex_valid_i (ex_valid), .wb_valid_i (wb_valid),
    .illegal_insn_i (illegal_insn), .eret_insn_i (eret_insn),
    .pipe_flush_i (pipe_flush), .jump_in_dec_i (jump_in_dec),
    .jump_in_id_i (jump_in_id), .branch_taken_ex_i (branch_taken_ex),
    .exc_req_i (exc_req), .data_req_ex_i (data_req_ex),
    .data_misaligned_i (data_misaligned), .mult_multicycle_i (mult_multicycle),
    .reg_ex_match_i (ex_match), .reg_wb_match_i (wb_match),
    .reg_alu_match_i (alu_match), .regfile_we_ex_i (we_ex),
    .regfile_we_wb_i (we_wb), .regfile_alu_we_i (alu_we),
    .core_busy_o (core_busy), .is_decoding_o (is_decoding),
    .instr_req_o (instr_req), .pc_set_o (pc_set), .pc_mux_o (pc_mux),
    .exc_ack_o (exc_ack), .exc_save_id_o (exc_save_id),
    .exc_restore_id_o (exc_restore_id), .halt_if_o (halt_if),
    .halt_id_o (halt_id), .deassert_we_o (deassert_we),
    .load_stall_o (load_stall), .jr_stall_o (jr_stall),
    .operand_a_fw_sel_o (fw_a), .operand_b_fw_sel_o (fw_b),
    .operand_c_fw_sel_o (fw_c)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic finish_run();
    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  endtask

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT)
    begin
      timeouts = timeouts + 1;
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      finish_run();
    end
  end

  // inputs change 2 ns after the rising edge
  task automatic next_drive_slot();
    @(posedge clk);
    #2;
  endtask

  // outputs are read half a cycle later
  task automatic to_sample_point();
    @(negedge clk);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      errors++;
      $display("** Error %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic check_pc_mux(input string name, input pc_mux_t exp, input pc_mux_t act);
    if (act !== exp)
    begin
      errors++;
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_fw_sel(input string name, input fw_sel_t exp, input fw_sel_t act);
    if (act !== exp)
    begin
      errors++;
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // priority: misaligned, multicycle mult, EX, WB, register file
  function automatic fw_sel_t expected_fw(input row_t r, input logic [1:0] idx);
    if (r.misaligned && idx == 2'd0)
      return SEL_FW_EX;
    if (r.misaligned && idx == 2'd1)
      return SEL_REGFILE;
    if (!r.misaligned && r.mult && idx == 2'd2)
      return SEL_FW_EX;
    if (r.alu_we && r.alu_m[idx])
      return SEL_FW_EX;
    if (r.we_wb && r.wb_m[idx])
      return SEL_FW_WB;
    return SEL_REGFILE;
  endfunction

  task automatic fill_table();
    row_t r;
    for (int i = 0; i < TABLE_LEN; i++)
    begin
      r            = '0;
      r.misaligned = (($urandom % 4) == 0);
      r.mult       = (($urandom % 3) == 0);
      r.data_req   = (($urandom % 2) == 1);
      r.illegal    = (($urandom % 5) == 0);
      r.jump       = jump_kind_t'($urandom % 4);
      r.ex_m       = operand_mask_t'($urandom);
      r.wb_m       = operand_mask_t'($urandom);
      r.alu_m      = operand_mask_t'($urandom);
      r.we_ex      = (($urandom % 2) == 1);
      r.we_wb      = (($urandom % 2) == 1);
      r.alu_we     = (($urandom % 2) == 1);
      r.exp_a      = expected_fw(r, 2'd0);
      r.exp_b      = expected_fw(r, 2'd1);
      r.exp_c      = expected_fw(r, 2'd2);
      // load in EX hits any operand
      r.exp_load   = r.data_req && r.we_ex && (r.ex_m != '0);
      // jalr waits for operand a from any stage
      r.exp_jr     = (r.jump == BRANCH_JALR) && ((r.we_wb && r.wb_m[0])
                     || (r.we_ex && r.ex_m[0]) || (r.alu_we && r.alu_m[0]));
      // decoding is active here, so only illegal or a stall drops the write
      r.exp_dwe    = r.illegal || r.exp_load || r.exp_jr;
      table_q[i]   = r;
    end
  endtask

  task automatic clear_inputs();
    {fetch_enable, instr_valid, id_ready, ex_valid, wb_valid} = '0;
    {illegal_insn, eret_insn, pipe_flush, branch_taken_ex, exc_req} = '0;
    {data_req_ex, data_misaligned, mult_multicycle} = '0;
    {we_ex, we_wb, alu_we} = '0;
    jump_in_dec = BRANCH_NONE;
    jump_in_id  = BRANCH_NONE;
    ex_match    = '0;
    wb_match    = '0;
    alu_match   = '0;
  endtask

  task automatic apply_row(input row_t r);
    data_misaligned = r.misaligned;
    mult_multicycle = r.mult;
    data_req_ex     = r.data_req;
    illegal_insn    = r.illegal;
    jump_in_dec     = r.jump;
    ex_match        = r.ex_m;
    wb_match        = r.wb_m;
    alu_match       = r.alu_m;
    we_ex           = r.we_ex;
    we_wb           = r.we_wb;
    alu_we          = r.alu_we;
  endtask

  task automatic wait_for_decode(input int max_cycles);
    int n;
    n = 0;
    while (!is_decoding && n < max_cycles)
    begin
      next_drive_slot();
      to_sample_point();
      n++;
    end
    if (!is_decoding)
    begin
      errors++;
      $display("controller never reached decode within %0d cycles", max_cycles);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int unsigned first_draw;
    string       tag;
    first_draw = $urandom(39073);
    clk   = 1'b0;
    rst_n = 1'b0;
    clear_inputs();
    fill_table();
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;

    // reset state, idle outputs
    to_sample_point();
    check_bit("reset instr_req", 1'b0, instr_req);
    check_bit("reset core_busy", 1'b0, core_busy);
    check_bit("reset pc_set", 1'b0, pc_set);
    check_bit("reset halt_if", 1'b0, halt_if);
    check_bit("reset deassert_we", 1'b1, deassert_we);

    // boot redirect one cycle after fetch enable
    next_drive_slot();
    fetch_enable = 1'b1;
    instr_valid  = 1'b1;
    next_drive_slot();
    to_sample_point();
    check_bit("boot pc_set", 1'b1, pc_set);
    check_pc_mux("boot pc_mux", PC_BOOT, pc_mux);
    check_bit("boot instr_req", 1'b1, instr_req);

    // first fetch holds while ID is not ready
    repeat (3)
    begin
      next_drive_slot();
      to_sample_point();
      check_bit("first fetch is_decoding", 1'b0, is_decoding);
    end
    next_drive_slot();
    id_ready = 1'b1;
    to_sample_point();
    wait_for_decode(20);

    // forwarding and stall table
    for (int i = 0; i < TABLE_LEN; i++)
    begin
      next_drive_slot();
      apply_row(table_q[i]);
      to_sample_point();
      tag = $sformatf("row %0d", i);
      check_fw_sel({tag, " fw a"}, table_q[i].exp_a, fw_a);
      check_fw_sel({tag, " fw b"}, table_q[i].exp_b, fw_b);
      check_fw_sel({tag, " fw c"}, table_q[i].exp_c, fw_c);
      check_bit({tag, " load_stall"}, table_q[i].exp_load, load_stall);
      check_bit({tag, " jr_stall"}, table_q[i].exp_jr, jr_stall);
      check_bit({tag, " deassert_we"}, table_q[i].exp_dwe, deassert_we);
    end
    next_drive_slot();
    apply_row('0);

    // jalr held until operand a leaves the alu path
    next_drive_slot();
    id_ready    = 1'b0;
    jump_in_dec = BRANCH_JALR;
    alu_match   = 3'b001;
    alu_we      = 1'b1;
    to_sample_point();
    check_bit("jalr stall jr_stall", 1'b1, jr_stall);
    check_bit("jalr stall pc_set", 1'b0, pc_set);
    check_bit("jalr stall deassert_we", 1'b1, deassert_we);
    next_drive_slot();
    alu_we = 1'b0;
    to_sample_point();
    check_bit("jalr release pc_set", 1'b1, pc_set);
    check_pc_mux("jalr release pc_mux", PC_JUMP, pc_mux);
    next_drive_slot();
    to_sample_point();
    check_bit("jalr no repeat pc_set", 1'b0, pc_set);
    next_drive_slot();
    jump_in_dec = BRANCH_NONE;
    alu_match   = '0;
    id_ready    = 1'b1;

    // jal redirects once while ID is held
    next_drive_slot();
    jump_in_dec = BRANCH_JAL;
    id_ready    = 1'b0;
    to_sample_point();
    check_bit("jal pc_set", 1'b1, pc_set);
    check_pc_mux("jal pc_mux", PC_JUMP, pc_mux);
    repeat (3)
    begin
      next_drive_slot();
      to_sample_point();
      check_bit("jal held pc_set", 1'b0, pc_set);
    end
    next_drive_slot();
    jump_in_dec = BRANCH_NONE;
    id_ready    = 1'b1;

    // taken branch kills the decode
    next_drive_slot();
    branch_taken_ex = 1'b1;
    to_sample_point();
    check_bit("branch pc_set", 1'b1, pc_set);
    check_pc_mux("branch pc_mux", PC_BRANCH, pc_mux);
    check_bit("branch is_decoding", 1'b0, is_decoding);

    // exception during a plain decode
    next_drive_slot();
    branch_taken_ex = 1'b0;
    exc_req         = 1'b1;
    to_sample_point();
    check_bit("exception pc_set", 1'b1, pc_set);
    check_pc_mux("exception pc_mux", PC_EXCEPTION, pc_mux);
    check_bit("exception exc_ack", 1'b1, exc_ack);
    check_bit("exception halt_id", 1'b1, halt_id);
    check_bit("exception exc_save_id", 1'b1, exc_save_id);

    // eret with fetch enabled stays in decode
    next_drive_slot();
    exc_req   = 1'b0;
    eret_insn = 1'b1;
    to_sample_point();
    check_bit("eret pc_set", 1'b1, pc_set);
    check_pc_mux("eret pc_mux", PC_ERET, pc_mux);
    check_bit("eret exc_restore_id", 1'b1, exc_restore_id);

    ////////////////////////////////////////////////////////////
    // flush into sleep, wake on exception
    ////////////////////////////////////////////////////////////

    next_drive_slot();
    eret_insn    = 1'b0;
    fetch_enable = 1'b0;
    pipe_flush   = 1'b1;
    to_sample_point();
    check_bit("flush halt_if", 1'b1, halt_if);
    check_bit("flush halt_id", 1'b1, halt_id);
    next_drive_slot();
    pipe_flush  = 1'b0;
    instr_valid = 1'b0;
    to_sample_point();
    check_bit("flush ex wait halt_if", 1'b1, halt_if);
    next_drive_slot();
    ex_valid = 1'b1;
    to_sample_point();
    check_bit("flush ex_valid halt_if", 1'b1, halt_if);
    next_drive_slot();
    ex_valid = 1'b0;
    to_sample_point();
    check_bit("flush wb wait halt_if", 1'b1, halt_if);
    next_drive_slot();
    wb_valid = 1'b1;
    to_sample_point();
    check_bit("flush wb_valid halt_if", 1'b1, halt_if);
    next_drive_slot();
    wb_valid = 1'b0;
    repeat (3)
    begin
      to_sample_point();
      check_bit("sleep core_busy", 1'b0, core_busy);
      check_bit("sleep instr_req", 1'b0, instr_req);
      next_drive_slot();
    end
    exc_req = 1'b1;
    to_sample_point();
    check_bit("wake request core_busy", 1'b0, core_busy);
    next_drive_slot();
    exc_req = 1'b0;
    to_sample_point();
    check_bit("woken core_busy", 1'b1, core_busy);
    check_bit("woken instr_req", 1'b1, instr_req);

    finish_run();
  end

endmodule

// ==== include/pipe_ctrl_config.svh ====
`ifndef PIPE_CTRL_CONFIG_SVH
`define PIPE_CTRL_CONFIG_SVH

////////////////////////////////////////////////////////////
// controller widths
////////////////////////////////////////////////////////////

// pc source select towards the fetch stage
`define CTRL_PC_MUX_W 3

// jump kind coming out of the decoder
`define CTRL_JUMP_W 2

// forwarding mux select per operand
`define CTRL_FW_SEL_W 2

// register operands read in ID: a, b and c
`define CTRL_NUM_OPERANDS 3

`endif

// ==== pipe_ctrl.f ====
+incdir+include
source/ctrl_pc_pkg.sv
source/ctrl_operand_pkg.sv
source/operand_match_if.sv
source/ctrl_fsm.sv
source/stall_ctrl.sv
source/fwd_ctrl.sv
source/pipe_ctrl.sv
bench/pipe_ctrl_assertions.sv
bench/pipe_ctrl_tb.sv

// ==== source/ctrl_fsm.sv ====
`timescale 1ns/1ps

module ctrl_fsm
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_enable_i,
  input  logic                    instr_valid_i,
  input  logic                    id_ready_i,
  input  logic                    ex_valid_i,
  input  logic                    wb_valid_i,
  input  logic                    eret_insn_i,
  input  logic                    pipe_flush_i,
  input  ctrl_pc_pkg::jump_kind_t jump_in_dec_i,
  input  logic                    branch_taken_ex_i,
  input  logic                    exc_req_i,
  input  logic                    jr_stall_i,
  output logic                    core_busy_o,
  output logic                    is_decoding_o,
  output logic                    instr_req_o,
  output logic                    pc_set_o,
  output ctrl_pc_pkg::pc_mux_t    pc_mux_o,
  output logic                    exc_ack_o,
  output logic                    exc_save_id_o,
  output logic                    exc_restore_id_o,
  output logic                    halt_if_o,
  output logic                    halt_id_o
);

  import ctrl_pc_pkg::*;

  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_t;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        jump_done_d;
  logic        jump_done_q;
  logic        uncond_jump;

  // jal and jalr know their target in ID already
  assign uncond_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d          = state_q;
    jump_done_d      = jump_done_q;
    instr_req_o      = 1'b1;
    core_busy_o      = 1'b1;
    is_decoding_o    = 1'b0;
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    exc_ack_o        = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;
    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;

    case (state_q)
      // idle until fetching is allowed
      RESET:
      begin
        instr_req_o = 1'b0;
        core_busy_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load boot address into the fetch stage
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // woken by fetch enable or a pending exception
      SLEEP:
      begin
        instr_req_o = 1'b0;
        core_busy_o = 1'b0;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = DECODE;
        if (exc_req_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_id_o = 1'b1;
        end
      end

      DECODE:
      begin
        // a taken branch in EX kills the instruction in ID
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (uncond_jump)
          begin
            pc_mux_o = PC_JUMP;
            // hold the redirect while the jalr operand is in flight
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            // keep the faulting instruction out of EX
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          if (eret_insn_i)
          begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi style flush, or eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        if (branch_taken_ex_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_BRANCH;
          is_decoding_o = 1'b0;
        end
      end

      // drain EX
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // drain WB, then sleep or resume
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        if (!fetch_enable_i)
        begin
          if (wb_valid_i)
            state_d = SLEEP;
        end
        else
        begin
          halt_if_o = 1'b0;
          if (id_ready_i)
            state_d = DECODE;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // cleared once ID takes the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

// ==== source/ctrl_operand_pkg.sv ====
`include "pipe_ctrl_config.svh"

package ctrl_operand_pkg;

  // one bit per source operand
  // bit 0 is a, bit 1 is b, bit 2 is c
  // a set bit means the destination register equals that source
  typedef logic [`CTRL_NUM_OPERANDS-1:0] operand_mask_t;

  ////////////////////////////////////////////////////////////
  // forwarding mux selects
  ////////////////////////////////////////////////////////////

  typedef logic [`CTRL_FW_SEL_W-1:0] fw_sel_t;

  // plain register file read
  localparam fw_sel_t SEL_REGFILE = 2'b00;
  // result from the EX stage (alu or multiplier)
  localparam fw_sel_t SEL_FW_EX   = 2'b01;
  // result being written back in WB
  localparam fw_sel_t SEL_FW_WB   = 2'b10;

endpackage

// ==== source/ctrl_pc_pkg.sv ====
`include "pipe_ctrl_config.svh"

package ctrl_pc_pkg;

  ////////////////////////////////////////////////////////////
  // pc redirect sources
  ////////////////////////////////////////////////////////////

  typedef logic [`CTRL_PC_MUX_W-1:0] pc_mux_t;

  // boot address, also the idle value of the select
  localparam pc_mux_t PC_BOOT      = 3'b000;
  localparam pc_mux_t PC_JUMP      = 3'b010;
  localparam pc_mux_t PC_BRANCH    = 3'b011;
  localparam pc_mux_t PC_EXCEPTION = 3'b100;
  // return from exception handler
  localparam pc_mux_t PC_ERET      = 3'b101;

  ////////////////////////////////////////////////////////////
  // jump kinds from the decoder
  ////////////////////////////////////////////////////////////

  typedef logic [`CTRL_JUMP_W-1:0] jump_kind_t;

  localparam jump_kind_t BRANCH_NONE = 2'b00;
  localparam jump_kind_t BRANCH_JAL  = 2'b01;
  localparam jump_kind_t BRANCH_JALR = 2'b10;
  // conditional branch, resolved in EX
  localparam jump_kind_t BRANCH_COND = 2'b11;

endpackage

// ==== source/fwd_ctrl.sv ====
`timescale 1ns/1ps

`include "pipe_ctrl_config.svh"

module fwd_ctrl
(
  input  logic                      data_misaligned_i,
  input  logic                      mult_multicycle_i,
  operand_match_if.fwd              match,
  output ctrl_operand_pkg::fw_sel_t operand_a_fw_sel_o,
  output ctrl_operand_pkg::fw_sel_t operand_b_fw_sel_o,
  output ctrl_operand_pkg::fw_sel_t operand_c_fw_sel_o
);

  import ctrl_operand_pkg::*;

  // mask bit positions
  localparam int unsigned OP_A = 0;
  localparam int unsigned OP_B = 1;
  localparam int unsigned OP_C = 2;

  fw_sel_t fw_sel [`CTRL_NUM_OPERANDS];

  always_comb
  begin
    for (int i = 0; i < `CTRL_NUM_OPERANDS; i++)
    begin
      fw_sel[i] = SEL_REGFILE;
      // WB result first, so EX below can override it
      if (match.we_wb && match.wb_match[i])
        fw_sel[i] = SEL_FW_WB;
      // the youngest value wins
      if (match.alu_we && match.alu_match[i])
        fw_sel[i] = SEL_FW_EX;
    end

    // second half of a misaligned access
    // a takes the incremented address from EX
    if (data_misaligned_i)
    begin
      fw_sel[OP_A] = SEL_FW_EX;
      fw_sel[OP_B] = SEL_REGFILE;
    end
    else if (mult_multicycle_i)
    begin
      // multiplier keeps its partial result on c
      fw_sel[OP_C] = SEL_FW_EX;
    end
  end

  assign operand_a_fw_sel_o = fw_sel[OP_A];
  assign operand_b_fw_sel_o = fw_sel[OP_B];
  assign operand_c_fw_sel_o = fw_sel[OP_C];

endmodule

// ==== source/operand_match_if.sv ====
`timescale 1ns/1ps

interface operand_match_if;

  import ctrl_operand_pkg::*;

  // destination vs source register matches, per pipeline stage
  operand_mask_t ex_match;
  operand_mask_t wb_match;
  operand_mask_t alu_match;

  // write enables belonging to the matches above
  logic          we_ex;
  logic          we_wb;
  logic          alu_we;

  // driven from the top level input ports
  modport src   (output ex_match, wb_match, alu_match, we_ex, we_wb, alu_we);

  // hazard detection looks at all three stages
  modport stall (input ex_match, wb_match, alu_match, we_ex, we_wb, alu_we);

  // forwarding only from WB and the alu path
  modport fwd   (input wb_match, alu_match, we_wb, alu_we);

endinterface

// ==== source/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl
(
  input  logic                         clk,
  input  logic                         rst_n,

  // handshakes and run control
  input  logic                         fetch_enable_i,
  input  logic                         instr_valid_i,
  input  logic                         id_ready_i,
  input  logic                         ex_valid_i,
  input  logic                         wb_valid_i,

  // decoder
  input  logic                         illegal_insn_i,
  input  logic                         eret_insn_i,
  input  logic                         pipe_flush_i,
  input  ctrl_pc_pkg::jump_kind_t      jump_in_dec_i,
  // jump kind of the instruction in ID
  input  ctrl_pc_pkg::jump_kind_t      jump_in_id_i,
  input  logic                         branch_taken_ex_i,
  input  logic                         exc_req_i,

  // lsu and multiplier
  input  logic                         data_req_ex_i,
  input  logic                         data_misaligned_i,
  input  logic                         mult_multicycle_i,

  // register match detection
  input  ctrl_operand_pkg::operand_mask_t reg_ex_match_i,
  input  ctrl_operand_pkg::operand_mask_t reg_wb_match_i,
  input  ctrl_operand_pkg::operand_mask_t reg_alu_match_i,
  input  logic                         regfile_we_ex_i,
  input  logic                         regfile_we_wb_i,
  input  logic                         regfile_alu_we_i,

  output logic                         core_busy_o,
  output logic                         is_decoding_o,
  output logic                         instr_req_o,
  output logic                         pc_set_o,
  output ctrl_pc_pkg::pc_mux_t         pc_mux_o,
  output logic                         exc_ack_o,
  output logic                         exc_save_id_o,
  output logic                         exc_restore_id_o,
  output logic                         halt_if_o,
  output logic                         halt_id_o,
  output logic                         deassert_we_o,
  output logic                         load_stall_o,
  output logic                         jr_stall_o,
  output ctrl_operand_pkg::fw_sel_t    operand_a_fw_sel_o,
  output ctrl_operand_pkg::fw_sel_t    operand_b_fw_sel_o,
  output ctrl_operand_pkg::fw_sel_t    operand_c_fw_sel_o
);

  ////////////////////////////////////////////////////////////
  // match bundle for hazard and forwarding logic
  ////////////////////////////////////////////////////////////

  operand_match_if match_if ();

  assign match_if.ex_match  = reg_ex_match_i;
  assign match_if.wb_match  = reg_wb_match_i;
  assign match_if.alu_match = reg_alu_match_i;
  assign match_if.we_ex     = regfile_we_ex_i;
  assign match_if.we_wb     = regfile_we_wb_i;
  assign match_if.alu_we    = regfile_alu_we_i;

  // run state and pc redirect
  ctrl_fsm i_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .wb_valid_i        (wb_valid_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .jr_stall_i        (jr_stall_o),
    .core_busy_o       (core_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ack_o         (exc_ack_o),
    .exc_save_id_o     (exc_save_id_o),
    .exc_restore_id_o  (exc_restore_id_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  // jr_stall goes back to the fsm, is_decoding comes from it
  stall_ctrl i_stall_ctrl (
    .data_req_ex_i  (data_req_ex_i),
    .illegal_insn_i (illegal_insn_i),
    .is_decoding_i  (is_decoding_o),
    .jump_in_dec_i  (jump_in_dec_i),
    .match          (match_if.stall),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  fwd_ctrl i_fwd_ctrl (
    .data_misaligned_i  (data_misaligned_i),
    .mult_multicycle_i  (mult_multicycle_i),
    .match              (match_if.fwd),
    .operand_a_fw_sel_o (operand_a_fw_sel_o),
    .operand_b_fw_sel_o (operand_b_fw_sel_o),
    .operand_c_fw_sel_o (operand_c_fw_sel_o)
  );

endmodule

// ==== source/stall_ctrl.sv ====
`timescale 1ns/1ps

module stall_ctrl
(
  input  logic                    data_req_ex_i,
  input  logic                    illegal_insn_i,
  input  logic                    is_decoding_i,
  input  ctrl_pc_pkg::jump_kind_t jump_in_dec_i,
  operand_match_if.stall          match,
  output logic                    load_stall_o,
  output logic                    jr_stall_o,
  output logic                    deassert_we_o
);

  import ctrl_pc_pkg::*;

  logic jalr_in_dec;
  logic a_pending;

  ////////////////////////////////////////////////////////////
  // hazard detection
  ////////////////////////////////////////////////////////////

  // load in EX writes a register that ID wants to read
  assign load_stall_o = data_req_ex_i & match.we_ex & (|match.ex_match);

  assign jalr_in_dec = (jump_in_dec_i == BRANCH_JALR);

  // operand a (bit 0) still has a write in flight somewhere
  // jalr needs it for the target address, so no forwarding here
  assign a_pending = (match.we_wb  & match.wb_match[0])
                   | (match.we_ex  & match.ex_match[0])
                   | (match.alu_we & match.alu_match[0]);

  // independent of the fsm state on purpose
  // outside DECODE the write enable is dropped anyway
  assign jr_stall_o = jalr_in_dec & a_pending;

  ////////////////////////////////////////////////////////////
  // write enable for the instruction leaving ID
  ////////////////////////////////////////////////////////////

  // no valid decode, illegal opcode, or any stall
  assign deassert_we_o = ~is_decoding_i
                       | illegal_insn_i
                       | load_stall_o
                       | jr_stall_o;

endmodule
